/* common/bnn_pkg.sv */
package bnn_pkg;

    // lane geometry
    localparam int LANES      = 16;
    localparam int GROUP_SIZE = 4;
    localparam int GROUPS     = LANES / GROUP_SIZE;

    // accumulator width, far above any realistic vote count
    localparam int ACC_W = 30;

    // one bit per lane, activation / weight / mask
    typedef logic [LANES-1:0] lane_vec_t;

    // signed vote, -1 / 0 / +1
    typedef logic signed [1:0] vote_t;

    // group of four votes, -4 .. +4
    typedef logic signed [3:0] group_sum_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    typedef logic [4:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map
    localparam apb_addr_t REG_WEIGHT = 5'h00;
    localparam apb_addr_t REG_MASK   = 5'h04;
    localparam apb_addr_t REG_CTRL   = 5'h08;
    localparam apb_addr_t REG_ACC    = 5'h0C;
    localparam apb_addr_t REG_STATUS = 5'h10;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_s;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_s;

    // activation stream, no back-pressure
    typedef struct packed {
        logic      valid;
        lane_vec_t bits;
    } act_beat_s;

    typedef struct packed {
        lane_vec_t weight;
        lane_vec_t mask;
        logic      clear;
    } neuron_cfg_s;

    typedef struct packed {
        acc_t acc;
        logic sign;
        logic busy;
    } neuron_stat_s;

endpackage

/* filelist.f */
common/bnn_pkg.sv
logic/apb_regs.sv
neuron/vote_unit.sv
neuron/vote_counter.sv
logic/bnn_neuron_top.sv
tb/tb_bnn_neuron.sv

/* logic/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  bnn_pkg::apb_req_s     apb_req,
    output bnn_pkg::apb_rsp_s     apb_rsp,
    output bnn_pkg::neuron_cfg_s  cfg,
    input  bnn_pkg::neuron_stat_s stat
);

    logic               access;
    logic               hit;
    logic               read_only;
    logic               bad;
    logic               wr_en;
    bnn_pkg::lane_vec_t weight_q;
    bnn_pkg::lane_vec_t mask_q;
    logic               clear_q;
    bnn_pkg::apb_data_t rdata;

    // access phase, setup already seen
    assign access = apb_req.psel & apb_req.penable;

    // address decode
    always_comb begin
        hit       = 1'b1;
        read_only = 1'b0;
        case (apb_req.paddr)
            bnn_pkg::REG_WEIGHT,
            bnn_pkg::REG_MASK,
            bnn_pkg::REG_CTRL: begin
                read_only = 1'b0;
            end
            bnn_pkg::REG_ACC,
            bnn_pkg::REG_STATUS: begin
                read_only = 1'b1;
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

    // unmapped, or a write to a read-only word
    assign bad   = ~hit | (apb_req.pwrite & read_only);
    assign wr_en = access & apb_req.pwrite & ~bad;

    // read mux
    always_comb begin
        rdata = '0;
        case (apb_req.paddr)
            bnn_pkg::REG_WEIGHT: rdata[bnn_pkg::LANES-1:0] = weight_q;
            bnn_pkg::REG_MASK:   rdata[bnn_pkg::LANES-1:0] = mask_q;
            // acc sign-extended to the bus width
            bnn_pkg::REG_ACC: begin
                rdata = {{($bits(bnn_pkg::apb_data_t) - bnn_pkg::ACC_W)
                          {stat.acc[bnn_pkg::ACC_W-1]}}, stat.acc};
            end
            bnn_pkg::REG_STATUS: rdata[1:0] = {stat.busy, stat.sign};
            default: rdata = '0;
        endcase
    end

    // zero wait states, response straight from decode
    assign apb_rsp.prdata  = (access & ~apb_req.pwrite) ? rdata : '0;
    assign apb_rsp.pready  = access;
    assign apb_rsp.pslverr = access & bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            weight_q <= '0;
            mask_q   <= '0;
            clear_q  <= 1'b0;
        end else begin
            // clear drops again unless rewritten
            clear_q <= 1'b0;
            if (wr_en) begin
                case (apb_req.paddr)
                    bnn_pkg::REG_WEIGHT: weight_q <= apb_req.pwdata[bnn_pkg::LANES-1:0];
                    bnn_pkg::REG_MASK:   mask_q   <= apb_req.pwdata[bnn_pkg::LANES-1:0];
                    bnn_pkg::REG_CTRL:   clear_q  <= apb_req.pwdata[0];
                    default: clear_q <= 1'b0;
                endcase
            end
        end
    end

    assign cfg.weight = weight_q;
    assign cfg.mask   = mask_q;
    assign cfg.clear  = clear_q;

    // pready only in an access phase that followed a setup phase
    a_pready_access: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable
                            && $past(apb_req.psel && !apb_req.penable)));

    // clear is a single-cycle pulse
    a_clear_pulse: assert property (@(posedge clk) disable iff (rst)
        cfg.clear |=> !cfg.clear);

endmodule

/* logic/bnn_neuron_top.sv */
`timescale 1ns/1ps

module bnn_neuron_top (
    input  logic               clk,
    input  logic               rst,
    input  bnn_pkg::apb_req_s  apb_req,
    output bnn_pkg::apb_rsp_s  apb_rsp,
    input  bnn_pkg::act_beat_s beat,
    output logic               sign
);

    bnn_pkg::neuron_cfg_s  cfg;
    bnn_pkg::neuron_stat_s stat;
    bnn_pkg::vote_t        votes [bnn_pkg::LANES];
    logic                  vote_valid;

    // register file on apb
    apb_regs u_apb_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cfg     (cfg),
        .stat    (stat)
    );

    // xnor voting, weight and mask sampled with the beat
    vote_unit u_vote_unit (
        .clk        (clk),
        .rst        (rst),
        .beat       (beat),
        .weight     (cfg.weight),
        .mask       (cfg.mask),
        .clear      (cfg.clear),
        .votes      (votes),
        .vote_valid (vote_valid)
    );

    // group adders and accumulator
    vote_counter u_vote_counter (
        .clk        (clk),
        .rst        (rst),
        .votes      (votes),
        .vote_valid (vote_valid),
        .clear      (cfg.clear),
        .stat       (stat)
    );

    // neuron output
    assign sign = stat.sign;

endmodule

/* neuron/vote_counter.sv */
`timescale 1ns/1ps

module vote_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  bnn_pkg::vote_t        votes [bnn_pkg::LANES],
    input  logic                  vote_valid,
    input  logic                  clear,
    output bnn_pkg::neuron_stat_s stat
);

    bnn_pkg::group_sum_t grp_next [bnn_pkg::GROUPS];
    bnn_pkg::group_sum_t grp_sum  [bnn_pkg::GROUPS];
    logic                grp_valid;
    bnn_pkg::acc_t       grp_total;
    bnn_pkg::acc_t       acc;

    // stage one adders, four lanes each
    always_comb begin
        for (int g = 0; g < bnn_pkg::GROUPS; g++) begin
            grp_next[g] = '0;
            for (int k = 0; k < bnn_pkg::GROUP_SIZE; k++) begin
                // sign-extend 2-bit vote
                grp_next[g] = grp_next[g]
                            + bnn_pkg::group_sum_t'(votes[g*bnn_pkg::GROUP_SIZE + k]);
            end
        end
    end

    // group sums, payload only
    always_ff @(posedge clk) begin
        if (vote_valid) begin
            grp_sum <= grp_next;
        end
    end

    // delayed valid for stage two
    always_ff @(posedge clk) begin
        if (rst) begin
            grp_valid <= 1'b0;
        end else begin
            grp_valid <= vote_valid & ~clear;
        end
    end

    // stage two, total of the group sums
    always_comb begin
        grp_total = '0;
        for (int g = 0; g < bnn_pkg::GROUPS; g++) begin
            grp_total = grp_total + bnn_pkg::acc_t'(grp_sum[g]);
        end
    end

    // separate stages so back-to-back beats each land once
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (clear) begin
            // clear wins over a beat arriving now
            acc <= '0;
        end else if (grp_valid) begin
            acc <= acc + grp_total;
        end
    end

    assign stat.acc  = acc;
    // sign straight off the register
    assign stat.sign = acc[bnn_pkg::ACC_W-1];
    // anything still in the pipe
    assign stat.busy = vote_valid | grp_valid;

    // group sum stays within four votes
    for (genvar g = 0; g < bnn_pkg::GROUPS; g++) begin : g_grp_chk
        a_grp_range: assert property (@(posedge clk) disable iff (rst)
            grp_valid |-> (grp_sum[g] >= -4 && grp_sum[g] <= 4));
    end

endmodule

/* neuron/vote_unit.sv */
`timescale 1ns/1ps

module vote_unit (
    input  logic               clk,
    input  logic               rst,
    input  bnn_pkg::act_beat_s beat,
    input  bnn_pkg::lane_vec_t weight,
    input  bnn_pkg::lane_vec_t mask,
    input  logic               clear,
    output bnn_pkg::vote_t     votes [bnn_pkg::LANES],
    output logic               vote_valid
);

    bnn_pkg::lane_vec_t agree;
    bnn_pkg::vote_t     next_vote [bnn_pkg::LANES];

    // xnor gives 1 where activation matches weight
    assign agree = ~(beat.bits ^ weight);

    // per-lane vote from agree and mask
    always_comb begin
        for (int i = 0; i < bnn_pkg::LANES; i++) begin
            if (!mask[i]) begin
                next_vote[i] = 2'sd0;
            end else if (agree[i]) begin
                next_vote[i] = 2'sd1;
            end else begin
                // mismatch votes -1
                next_vote[i] = -2'sd1;
            end
        end
    end

    // payload loaded only with a beat
    always_ff @(posedge clk) begin
        if (beat.valid) begin
            votes <= next_vote;
        end
    end

    // valid flag killed by clear
    always_ff @(posedge clk) begin
        if (rst) begin
            vote_valid <= 1'b0;
        end else begin
            vote_valid <= beat.valid & ~clear;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it
# a failing check ends the run with a nonzero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_bnn_neuron \
    -o sim_bnn_neuron

./obj_dir/sim_bnn_neuron

/* tb/tb_bnn_neuron.sv */
`timescale 1ns/1ps

module tb_bnn_neuron;

    // about 30 apb accesses and at most ~200 beats, far below this
    localparam int MAX_CYCLES = 2000;

    logic                  clk;
    logic                  rst;
    bnn_pkg::apb_req_s     apb_req;
    bnn_pkg::apb_rsp_s     apb_rsp;
    bnn_pkg::act_beat_s    beat;
    logic                  sign;
    logic                  apb_access;

    // expected response, loaded with the access phase
    bnn_pkg::apb_data_t    exp_rdata;
    logic                  exp_slverr;
    logic                  chk_rdata;
    logic                  exp_sign;
    logic                  chk_sign;

    // reference model state
    bnn_pkg::lane_vec_t    cur_weight;
    bnn_pkg::lane_vec_t    cur_mask;
    int                    model_acc;
    logic [15:0]           lfsr;
    int                    cycles = 0;

    bnn_neuron_top UUT (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .beat    (beat),
        .sign    (sign)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "check failed");
    endtask

    assign apb_access = apb_req.psel & apb_req.penable;

    a_pready: assert property (@(posedge clk) disable iff (rst)
        apb_access |-> apb_rsp.pready)
        else report_error("pready low in an access phase");
    // outside an access phase the response stays quiet
    a_idle: assert property (@(posedge clk) disable iff (rst)
        !apb_access |-> (!apb_rsp.pready && !apb_rsp.pslverr))
        else report_error("pready or pslverr high outside an access phase");
    a_slverr: assert property (@(posedge clk) disable iff (rst)
        apb_access |-> (apb_rsp.pslverr == exp_slverr))
        else report_error($sformatf("pslverr %b, expected %b",
                                    $sampled(apb_rsp.pslverr), $sampled(exp_slverr)));
    a_rdata: assert property (@(posedge clk) disable iff (rst)
        (apb_access && chk_rdata) |-> (apb_rsp.prdata == exp_rdata))
        else report_error($sformatf("prdata %h, expected %h",
                                    $sampled(apb_rsp.prdata), $sampled(exp_rdata)));
    a_sign: assert property (@(posedge clk) disable iff (rst)
        chk_sign |-> (sign == exp_sign))
        else report_error($sformatf("sign %b, expected %b", $sampled(sign), $sampled(exp_sign)));

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_bit();
        lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        return lfsr[0];
    endfunction

    function automatic bnn_pkg::lane_vec_t random_lanes();
        bnn_pkg::lane_vec_t v;
        for (int i = 0; i < bnn_pkg::LANES; i++) begin
            v[i] = next_bit();
        end
        return v;
    endfunction

    // setup phase, access phase, then idle
    task automatic apb_cycle(input bnn_pkg::apb_addr_t addr, input logic write,
                             input bnn_pkg::apb_data_t data, input logic err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= write ? data : '0;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        exp_slverr      <= err;
        exp_rdata       <= data;
        chk_rdata       <= ~write;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        chk_rdata       <= 1'b0;
    endtask

    // model adds the votes with the weight and mask in force now
    task automatic send_beat(input bnn_pkg::lane_vec_t bits);
        int votes;
        votes = 0;
        for (int i = 0; i < bnn_pkg::LANES; i++) begin
            if (cur_mask[i]) begin
                votes = votes + ((bits[i] == cur_weight[i]) ? 1 : -1);
            end
        end
        model_acc = model_acc + votes;
        @(posedge clk);
        beat.valid <= 1'b1;
        beat.bits  <= bits;
    endtask

    // drop valid, then the three-stage latency
    task automatic end_stream();
        @(posedge clk);
        beat.valid <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin : stimulus
        apb_req    = '0;
        beat       = '0;
        exp_rdata  = '0;
        exp_slverr = 1'b0;
        chk_rdata  = 1'b0;
        exp_sign   = 1'b0;
        chk_sign   = 1'b0;
        model_acc  = 0;
        lfsr       = 16'd13;
        rst        = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // weight and mask read back
        cur_weight = random_lanes();
        cur_mask   = '1;
        apb_cycle(bnn_pkg::REG_WEIGHT, 1'b1, bnn_pkg::apb_data_t'(cur_weight), 1'b0);
        apb_cycle(bnn_pkg::REG_MASK, 1'b1, bnn_pkg::apb_data_t'(cur_mask), 1'b0);
        apb_cycle(bnn_pkg::REG_WEIGHT, 1'b0, bnn_pkg::apb_data_t'(cur_weight), 1'b0);
        apb_cycle(bnn_pkg::REG_MASK, 1'b0, bnn_pkg::apb_data_t'(cur_mask), 1'b0);

        // 40 back-to-back beats, all lanes voting
        for (int n = 0; n < 40; n++) begin
            send_beat(random_lanes());
        end
        end_stream();
        apb_cycle(bnn_pkg::REG_ACC, 1'b0, bnn_pkg::apb_data_t'(model_acc), 1'b0);

        // upper half of the lanes masked off
        cur_mask = 16'h00FF;
        apb_cycle(bnn_pkg::REG_MASK, 1'b1, bnn_pkg::apb_data_t'(cur_mask), 1'b0);
        for (int n = 0; n < 30; n++) begin
            send_beat(random_lanes());
        end
        end_stream();
        apb_cycle(bnn_pkg::REG_ACC, 1'b0, bnn_pkg::apb_data_t'(model_acc), 1'b0);

        // opposing beats until the sum goes negative
        do begin
            send_beat(~cur_weight);
        end while (model_acc >= 0);
        end_stream();
        exp_sign <= 1'b1;
        chk_sign <= 1'b1;
        // busy 0, sign 1
        apb_cycle(bnn_pkg::REG_STATUS, 1'b0, 32'h0000_0001, 1'b0);
        apb_cycle(bnn_pkg::REG_ACC, 1'b0, bnn_pkg::apb_data_t'(model_acc), 1'b0);

        // clear command
        chk_sign <= 1'b0;
        apb_cycle(bnn_pkg::REG_CTRL, 1'b1, 32'h0000_0001, 1'b0);
        model_acc = 0;
        apb_cycle(bnn_pkg::REG_ACC, 1'b0, 32'h0000_0000, 1'b0);
        exp_sign <= 1'b0;
        chk_sign <= 1'b1;
        apb_cycle(bnn_pkg::REG_STATUS, 1'b0, 32'h0000_0000, 1'b0);

        // bad accesses leave the accumulator alone
        chk_sign <= 1'b0;
        for (int n = 0; n < 8; n++) begin
            send_beat(random_lanes());
        end
        end_stream();
        apb_cycle(bnn_pkg::REG_ACC, 1'b0, bnn_pkg::apb_data_t'(model_acc), 1'b0);
        apb_cycle(5'h14, 1'b0, 32'h0000_0000, 1'b1);
        apb_cycle(bnn_pkg::REG_ACC, 1'b1, 32'h1234_5678, 1'b1);
        apb_cycle(bnn_pkg::REG_STATUS, 1'b1, 32'h0000_0003, 1'b1);
        apb_cycle(5'h1C, 1'b1, 32'hFFFF_FFFF, 1'b1);
        apb_cycle(bnn_pkg::REG_ACC, 1'b0, bnn_pkg::apb_data_t'(model_acc), 1'b0);
        apb_cycle(bnn_pkg::REG_WEIGHT, 1'b0, bnn_pkg::apb_data_t'(cur_weight), 1'b0);

        repeat (2) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule
